//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "no final result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_issue.sv
verilog/exu_alu.sv
verilog/exu_mul.sv
verilog/exu_result_buf.sv
verilog/exu_top.sv
dv/exu_assertions.sv
dv/exu_tb.sv

//--- dv/exu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_assertions (
    input wire                      clk,
    input wire                      rst,
    input wire                      flush,
    input wire                      in_valid,
    input wire                      in_ready,
    input wire exu_pkg::alu_op_t    op,
    input wire exu_pkg::opnd_sel_t  sel_a,
    input wire exu_pkg::opnd_sel_t  sel_b,
    input wire                      word,
    input wire exu_pkg::xlen_t      pc,
    input wire exu_pkg::xlen_t      rs1,
    input wire exu_pkg::xlen_t      rs2,
    input wire exu_pkg::xlen_t      csr,
    input wire exu_pkg::xlen_t      imm,
    input wire                      out_valid,
    input wire                      out_ready,
    input wire exu_pkg::xlen_t      res,
    input wire                      mul_start,
    input wire                      mul_done
);

    int   assert_fails = 0;
    logic flushed_q;

    // set by flush, cleared once a new operation is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            flushed_q <= 1'b0;
        end else if (flush) begin
            flushed_q <= 1'b1;
        end else if (in_valid && in_ready) begin
            flushed_q <= 1'b0;
        end
    end

    // request held until taken
    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready && !flush |=> in_valid && $stable(op) && $stable(sel_a)
            && $stable(sel_b) && $stable(word) && $stable(pc) && $stable(rs1)
            && $stable(rs2) && $stable(csr) && $stable(imm))
        else begin
            assert_fails++;
            $error("input request changed before it was accepted");
        end

    res_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> out_valid && $stable(res))
        else begin
            assert_fails++;
            $error("result changed under back-pressure");
        end

    // done is a single-cycle pulse, a fixed number of cycles after its start
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> $past(mul_start, `EXU_MUL_STEPS + 1) && !$past(mul_done))
        else begin
            assert_fails++;
            $error("mul_done not a single pulse at the expected distance from mul_start");
        end

    // nothing comes out between a flush and the next accepted operation
    flush_clear: assert property (@(posedge clk) disable iff (rst)
        flushed_q |-> !out_valid)
        else begin
            assert_fails++;
            $error("out_valid high after flush before a new operation was accepted");
        end

endmodule

bind exu_top exu_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op        (op),
    .sel_a     (sel_a),
    .sel_b     (sel_b),
    .word      (word),
    .pc        (pc),
    .rs1       (rs1),
    .rs2       (rs2),
    .csr       (csr),
    .imm       (imm),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .res       (res),
    .mul_start (mul_start),
    .mul_done  (mul_done)
);

`default_nettype wire

//--- dv/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    localparam int WAIT_LIMIT = 200;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                in_valid;
    wire                 in_ready;
    exu_pkg::alu_op_t    op;
    exu_pkg::opnd_sel_t  sel_a;
    exu_pkg::opnd_sel_t  sel_b;
    logic                word;
    exu_pkg::xlen_t      pc;
    exu_pkg::xlen_t      rs1;
    exu_pkg::xlen_t      rs2;
    exu_pkg::xlen_t      csr;
    exu_pkg::xlen_t      imm;
    wire                 out_valid;
    logic                out_ready = 1'b0;
    wire exu_pkg::xlen_t res;

    logic           ready_fixed = 1'b1;
    logic           bp_en = 1'b0;
    logic           next_ready;
    logic           aborted = 1'b0;
    logic           out_valid_d = 1'b0;
    exu_pkg::xlen_t exp_q[$];
    string          test_name = "reset";
    int             cyc = 0;
    int             accept_cyc = 0;
    int             rise_cyc = 0;
    int             err_cnt = 0;
    int             check_cnt = 0;
    int             test_cnt = 0;
    int             test_fail_cnt = 0;
    int             test_err0 = 0;

    exu_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word      (word),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // sink side, fixed or random ready
    always @(posedge clk) begin
        next_ready = bp_en ? 1'($urandom % 2) : ready_fixed;
        #1;
        out_ready = next_ready;
    end

    task automatic check_data(input string name, input exu_pkg::xlen_t exp,
                              input exu_pkg::xlen_t act);
        check_cnt++;
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        if (!aborted) begin
            $display("timeout in test %s while waiting for %s", test_name, what);
            err_cnt++;
            aborted = 1'b1;
        end
    endtask

    // sampled mid-cycle, transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && !out_valid_d) begin
                rise_cyc = cyc;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("result %h came out with nothing expected in test %s",
                             res, test_name);
                    err_cnt++;
                end else begin
                    check_data(test_name, exp_q.pop_front(), res);
                end
            end
        end
        out_valid_d = out_valid;
    end

    // reference model from the operand and opcode rules
    function automatic exu_pkg::xlen_t model_result(
        input exu_pkg::alu_op_t o, input exu_pkg::opnd_sel_t sa,
        input exu_pkg::opnd_sel_t sb, input logic w, input exu_pkg::xlen_t p,
        input exu_pkg::xlen_t r1, input exu_pkg::xlen_t r2, input exu_pkg::xlen_t c,
        input exu_pkg::xlen_t im);
        exu_pkg::xlen_t a;
        exu_pkg::xlen_t b;
        exu_pkg::xlen_t a_sext;
        int             sh;
        if (sa == `EXU_SEL_RS1) begin
            a = w ? {32'h0, r1[31:0]} : r1;
        end else begin
            a = p;
        end
        if (sb == `EXU_SEL_RS2) begin
            b = r2;
        end else if (sb == `EXU_SEL_CSR) begin
            b = c;
        end else begin
            b = im;
        end
        sh = int'(b[5:0]);
        a_sext = {{32{a[31]}}, a[31:0]};
        case (o)
            `EXU_OP_ADD:    return a + b;
            `EXU_OP_SUB:    return a - b;
            `EXU_OP_PASS_A: return a;
            `EXU_OP_PASS_B: return b;
            `EXU_OP_XOR:    return a ^ b;
            `EXU_OP_OR:     return a | b;
            `EXU_OP_AND:    return a & b;
            `EXU_OP_SLL:    return a << sh;
            `EXU_OP_SRL:    return a >> sh;
            `EXU_OP_SRA: begin
                if (w) begin
                    a_sext = $signed(a_sext) >>> sh;
                    return {32'h0, a_sext[31:0]};
                end
                return $signed(a) >>> sh;
            end
            `EXU_OP_SLT:    return {63'h0, $signed(a) < $signed(b)};
            `EXU_OP_SLTU:   return {63'h0, a < b};
            `EXU_OP_EQ:     return {63'h0, a == b};
            `EXU_OP_SGE:    return {63'h0, $signed(a) >= $signed(b)};
            `EXU_OP_SGEU:   return {63'h0, a >= b};
            `EXU_OP_MUL:    return a * b;
            default:        return '0;
        endcase
    endfunction

    function automatic exu_pkg::xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // mostly defined codes, some unused ones
    function automatic exu_pkg::alu_op_t random_alu_op();
        if ($urandom % 8 == 0) begin
            return exu_pkg::alu_op_t'(16 + $urandom % 16);
        end
        return exu_pkg::alu_op_t'($urandom % 15);
    endfunction

    // called at posedge+1, returns at posedge+1 after the transfer
    task automatic send_op(input exu_pkg::alu_op_t o, input exu_pkg::opnd_sel_t sa,
                           input exu_pkg::opnd_sel_t sb, input logic w,
                           input exu_pkg::xlen_t p, input exu_pkg::xlen_t r1,
                           input exu_pkg::xlen_t r2, input exu_pkg::xlen_t c,
                           input exu_pkg::xlen_t im, input logic keep);
        int n;
        n = 0;
        op = o;
        sel_a = sa;
        sel_b = sb;
        word = w;
        pc = p;
        rs1 = r1;
        rs2 = r2;
        csr = c;
        imm = im;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready && n < WAIT_LIMIT && !aborted) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            report_timeout("operation accept");
        end else begin
            accept_cyc = cyc;
            if (keep) begin
                exp_q.push_back(model_result(o, sa, sb, w, p, r1, r2, c, im));
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_random(input exu_pkg::alu_op_t o, input logic keep);
        exu_pkg::xlen_t r1;
        exu_pkg::xlen_t r2;
        r1 = rand_word();
        r2 = ($urandom % 4 == 0) ? r1 : rand_word();
        send_op(o, exu_pkg::opnd_sel_t'($urandom % 4), exu_pkg::opnd_sel_t'($urandom % 4),
                1'($urandom % 2), rand_word(), r1, r2, rand_word(), rand_word(), keep);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT && !aborted) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("results to drain");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!out_valid && n < WAIT_LIMIT && !aborted) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            report_timeout("buffered result");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        check_flag({test_name, " in_ready"}, 1'b1, in_ready);
        check_flag({test_name, " out_valid"}, 1'b0, out_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == test_err0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, err_cnt - test_err0);
            test_fail_cnt++;
        end
    endtask

    initial begin
        void'($urandom(32'h522a));
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        op = '0;
        sel_a = '0;
        sel_b = '0;
        word = 1'b0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        csr = '0;
        imm = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("random_alu");
        repeat (200) send_random(random_alu_op(), 1'b1);
        drain();
        end_test();

        begin_test("random_mul");
        send_op(`EXU_OP_MUL, `EXU_SEL_RS1, `EXU_SEL_RS2, 1'b0, rand_word(), '0,
                rand_word(), rand_word(), rand_word(), 1'b1);
        send_op(`EXU_OP_MUL, `EXU_SEL_RS1, `EXU_SEL_RS2, 1'b0, rand_word(), '1,
                '1, rand_word(), rand_word(), 1'b1);
        send_op(`EXU_OP_MUL, `EXU_SEL_RS1, `EXU_SEL_CSR, 1'b1, rand_word(), rand_word(),
                rand_word(), rand_word(), rand_word(), 1'b1);
        repeat (20) send_random(`EXU_OP_MUL, 1'b1);
        drain();
        end_test();

        begin_test("backpressure");
        bp_en = 1'b1;
        repeat (150) begin
            send_random(($urandom % 6 == 0) ? `EXU_OP_MUL : random_alu_op(), 1'b1);
        end
        drain();
        bp_en = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        end_test();

        begin_test("alu_latency");
        repeat (5) begin
            send_random(exu_pkg::alu_op_t'($urandom % 15), 1'b1);
            drain();
            check_cycles("alu_latency", 2, rise_cyc - accept_cyc);
        end
        end_test();

        begin_test("mul_latency");
        repeat (3) begin
            send_random(`EXU_OP_MUL, 1'b1);
            drain();
            check_cycles("mul_latency", 35, rise_cyc - accept_cyc);
        end
        end_test();

        begin_test("flush");
        // abort a multiply halfway
        send_random(`EXU_OP_MUL, 1'b0);
        repeat (10) @(posedge clk);
        #1;
        pulse_flush();
        repeat (40) @(posedge clk);
        #1;
        // drop a result held under back-pressure
        ready_fixed = 1'b0;
        send_random(`EXU_OP_ADD, 1'b0);
        wait_out_valid();
        pulse_flush();
        ready_fixed = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        send_random(random_alu_op(), 1'b1);
        drain();
        send_random(`EXU_OP_MUL, 1'b1);
        drain();
        end_test();

        err_cnt = err_cnt + u_dut.u_assertions.assert_fails;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt,
                 u_dut.u_assertions.assert_fails);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  wire exu_pkg::xlen_t    opnd_a,
    input  wire exu_pkg::xlen_t    opnd_b,
    input  wire exu_pkg::alu_op_t  op,
    input  wire                    word,
    output exu_pkg::xlen_t         alu_res
);

    logic [5:0]     shamt;
    logic [31:0]    sra_w;
    exu_pkg::xlen_t sra_d;

    assign shamt = opnd_b[5:0];

    // word form shifts only the low half, result zero-extended
    assign sra_w = $signed(opnd_a[31:0]) >>> shamt;
    assign sra_d = $signed(opnd_a) >>> shamt;

    always_comb begin
        case (op)
            `EXU_OP_ADD: begin
                alu_res = opnd_a + opnd_b;
            end
            `EXU_OP_SUB: begin
                alu_res = opnd_a - opnd_b;
            end
            `EXU_OP_PASS_A: begin
                alu_res = opnd_a;
            end
            `EXU_OP_PASS_B: begin
                alu_res = opnd_b;
            end
            `EXU_OP_XOR: begin
                alu_res = opnd_a ^ opnd_b;
            end
            `EXU_OP_OR: begin
                alu_res = opnd_a | opnd_b;
            end
            `EXU_OP_AND: begin
                alu_res = opnd_a & opnd_b;
            end
            `EXU_OP_SLL: begin
                alu_res = opnd_a << shamt;
            end
            `EXU_OP_SRL: begin
                alu_res = opnd_a >> shamt;
            end
            `EXU_OP_SRA: begin
                alu_res = word ? {{(`EXU_XLEN-32){1'b0}}, sra_w} : sra_d;
            end
            // compares give 0 or 1
            `EXU_OP_SLT: begin
                alu_res = exu_pkg::xlen_t'($signed(opnd_a) < $signed(opnd_b));
            end
            `EXU_OP_SLTU: begin
                alu_res = exu_pkg::xlen_t'(opnd_a < opnd_b);
            end
            `EXU_OP_EQ: begin
                alu_res = exu_pkg::xlen_t'(opnd_a == opnd_b);
            end
            `EXU_OP_SGE: begin
                alu_res = exu_pkg::xlen_t'($signed(opnd_a) >= $signed(opnd_b));
            end
            `EXU_OP_SGEU: begin
                alu_res = exu_pkg::xlen_t'(opnd_a >= opnd_b);
            end
            // product comes from the multiplier
            `EXU_OP_MUL: begin
                alu_res = '0;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath width
`define EXU_XLEN      64

// radix-4 multiplier retires two multiplier bits per step
`define EXU_MUL_STEPS 32

`define EXU_OP_W      5
`define EXU_SEL_W     2

// operation codes
`define EXU_OP_ADD    5'd0
`define EXU_OP_SUB    5'd1
`define EXU_OP_PASS_A 5'd2
`define EXU_OP_PASS_B 5'd3
`define EXU_OP_XOR    5'd4
`define EXU_OP_OR     5'd5
`define EXU_OP_AND    5'd6
`define EXU_OP_SLL    5'd7
`define EXU_OP_SRL    5'd8
`define EXU_OP_SRA    5'd9
`define EXU_OP_SLT    5'd10
`define EXU_OP_SLTU   5'd11
`define EXU_OP_EQ     5'd12
`define EXU_OP_SGE    5'd13
`define EXU_OP_SGEU   5'd14
`define EXU_OP_MUL    5'd15

// operand select codes
`define EXU_SEL_PC    2'd0
`define EXU_SEL_RS1   2'd1
`define EXU_SEL_RS2   2'd1
`define EXU_SEL_CSR   2'd2
`define EXU_SEL_IMM   2'd3

`endif

//--- verilog/exu_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_issue (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire exu_pkg::alu_op_t    op,
    input  wire exu_pkg::opnd_sel_t  sel_a,
    input  wire exu_pkg::opnd_sel_t  sel_b,
    input  wire                      word,
    input  wire exu_pkg::xlen_t      pc,
    input  wire exu_pkg::xlen_t      rs1,
    input  wire exu_pkg::xlen_t      rs2,
    input  wire exu_pkg::xlen_t      csr,
    input  wire exu_pkg::xlen_t      imm,
    input  wire                      buf_ready,
    input  wire                      mul_done,
    output exu_pkg::xlen_t           opnd_a,
    output exu_pkg::xlen_t           opnd_b,
    output exu_pkg::alu_op_t         issue_op,
    output logic                     issue_word,
    output logic                     alu_wr_valid,
    output logic                     mul_start,
    output exu_pkg::xlen_t           mul_a,
    output exu_pkg::xlen_t           mul_b
);

    logic             full_q;
    logic             mul_busy_q;
    logic             accept;
    logic             is_mul;
    exu_pkg::alu_op_t op_q;
    logic             word_q;
    exu_pkg::xlen_t   a_q;
    exu_pkg::xlen_t   b_q;
    exu_pkg::xlen_t   sel_a_val;
    exu_pkg::xlen_t   sel_b_val;

    // operand muxes ahead of the issue register
    always_comb begin
        case (sel_a)
            `EXU_SEL_RS1: sel_a_val = word ? {{(`EXU_XLEN-32){1'b0}}, rs1[31:0]} : rs1;
            `EXU_SEL_PC:  sel_a_val = pc;
            default:      sel_a_val = pc;
        endcase
        case (sel_b)
            `EXU_SEL_RS2: sel_b_val = rs2;
            `EXU_SEL_CSR: sel_b_val = csr;
            `EXU_SEL_IMM: sel_b_val = imm;
            default:      sel_b_val = imm;
        endcase
    end

    assign in_ready = ~full_q;
    assign accept   = in_valid & in_ready;
    assign is_mul   = (op_q == `EXU_OP_MUL);

    assign alu_wr_valid = full_q & ~is_mul;
    // one start pulse, only while the result buffer can take the product
    assign mul_start    = full_q & is_mul & ~mul_busy_q & buf_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            full_q     <= 1'b0;
            mul_busy_q <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
            end else if ((alu_wr_valid && buf_ready) || mul_done) begin
                full_q <= 1'b0;
            end
            if (mul_start) begin
                mul_busy_q <= 1'b1;
            end else if (mul_done) begin
                mul_busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            word_q <= word;
            a_q    <= sel_a_val;
            b_q    <= sel_b_val;
        end
    end

    assign opnd_a     = a_q;
    assign opnd_b     = b_q;
    assign issue_op   = op_q;
    assign issue_word = word_q;
    assign mul_a      = a_q;
    assign mul_b      = b_q;

endmodule

`default_nettype wire

//--- verilog/exu_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_mul (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  flush,
    input  wire                  mul_start,
    input  wire exu_pkg::xlen_t  mul_a,
    input  wire exu_pkg::xlen_t  mul_b,
    output logic                 mul_done,
    output exu_pkg::xlen_t       mul_prod
);

    localparam int CNT_W = $clog2(`EXU_MUL_STEPS);

    exu_pkg::mul_state_e state;
    logic [CNT_W-1:0]    step_cnt;
    exu_pkg::xlen_t      acc;
    exu_pkg::xlen_t      mcand;
    exu_pkg::xlen_t      mplier;
    exu_pkg::xlen_t      partial;

    // 0..3 times the multiplicand, picked by the two low multiplier bits
    always_comb begin
        case (mplier[1:0])
            2'd0:    partial = '0;
            2'd1:    partial = mcand;
            2'd2:    partial = mcand << 1;
            default: partial = mcand + (mcand << 1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state    <= exu_pkg::IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                exu_pkg::IDLE: begin
                    if (mul_start) begin
                        state    <= exu_pkg::RUN;
                        step_cnt <= '0;
                    end
                end
                exu_pkg::RUN: begin
                    if (step_cnt == CNT_W'(`EXU_MUL_STEPS - 1)) begin
                        state <= exu_pkg::DONE;
                    end
                    step_cnt <= step_cnt + 1'b1;
                end
                exu_pkg::DONE: begin
                    state <= exu_pkg::IDLE;
                end
                default: begin
                    state <= exu_pkg::IDLE;
                end
            endcase
        end
    end

    // only the low 64 bits are kept, upper carries fall off
    always_ff @(posedge clk) begin
        if (state == exu_pkg::IDLE && mul_start) begin
            acc    <= '0;
            mcand  <= mul_a;
            mplier <= mul_b;
        end else if (state == exu_pkg::RUN) begin
            acc    <= acc + partial;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
        end
    end

    assign mul_done = (state == exu_pkg::DONE);
    assign mul_prod = acc;

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    // one data word
    typedef logic [`EXU_XLEN-1:0] xlen_t;

    // operation code as carried with each request
    typedef logic [`EXU_OP_W-1:0] alu_op_t;

    // operand select code
    typedef logic [`EXU_SEL_W-1:0] opnd_sel_t;

    // multiplier sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } mul_state_e;

endpackage

`default_nettype wire

//--- verilog/exu_result_buf.sv
`timescale 1ns/1ps
`default_nettype none

module exu_result_buf (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  flush,
    input  wire                  alu_wr_valid,
    input  wire exu_pkg::xlen_t  alu_res,
    input  wire                  mul_done,
    input  wire exu_pkg::xlen_t  mul_prod,
    input  wire                  out_ready,
    output logic                 buf_ready,
    output logic                 out_valid,
    output exu_pkg::xlen_t       res
);

    logic           valid_q;
    logic           wr_en;
    exu_pkg::xlen_t data_q;

    // free when empty or emptied this cycle
    assign buf_ready = ~valid_q | out_ready;

    // buffer is known empty when mul_done arrives
    assign wr_en = (alu_wr_valid & buf_ready) | mul_done;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (wr_en) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q <= mul_done ? mul_prod : alu_res;
        end
    end

    assign out_valid = valid_q;
    assign res       = data_q;

endmodule

`default_nettype wire

//--- verilog/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush,
    input  wire                      in_valid,
    output wire                      in_ready,
    input  wire exu_pkg::alu_op_t    op,
    input  wire exu_pkg::opnd_sel_t  sel_a,
    input  wire exu_pkg::opnd_sel_t  sel_b,
    input  wire                      word,
    input  wire exu_pkg::xlen_t      pc,
    input  wire exu_pkg::xlen_t      rs1,
    input  wire exu_pkg::xlen_t      rs2,
    input  wire exu_pkg::xlen_t      csr,
    input  wire exu_pkg::xlen_t      imm,
    output wire                      out_valid,
    input  wire                      out_ready,
    output wire exu_pkg::xlen_t      res
);

    wire exu_pkg::xlen_t   opnd_a;
    wire exu_pkg::xlen_t   opnd_b;
    wire exu_pkg::alu_op_t issue_op;
    wire                   issue_word;
    wire exu_pkg::xlen_t   alu_res;
    wire                   alu_wr_valid;
    wire                   buf_ready;
    wire                   mul_start;
    wire exu_pkg::xlen_t   mul_a;
    wire exu_pkg::xlen_t   mul_b;
    wire                   mul_done;
    wire exu_pkg::xlen_t   mul_prod;

    exu_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .op           (op),
        .sel_a        (sel_a),
        .sel_b        (sel_b),
        .word         (word),
        .pc           (pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .csr          (csr),
        .imm          (imm),
        .buf_ready    (buf_ready),
        .mul_done     (mul_done),
        .opnd_a       (opnd_a),
        .opnd_b       (opnd_b),
        .issue_op     (issue_op),
        .issue_word   (issue_word),
        .alu_wr_valid (alu_wr_valid),
        .mul_start    (mul_start),
        .mul_a        (mul_a),
        .mul_b        (mul_b)
    );

    exu_alu u_alu (
        .opnd_a  (opnd_a),
        .opnd_b  (opnd_b),
        .op      (issue_op),
        .word    (issue_word),
        .alu_res (alu_res)
    );

    exu_mul u_mul (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .mul_start (mul_start),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_done  (mul_done),
        .mul_prod  (mul_prod)
    );

    exu_result_buf u_result_buf (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alu_wr_valid (alu_wr_valid),
        .alu_res      (alu_res),
        .mul_done     (mul_done),
        .mul_prod     (mul_prod),
        .out_ready    (out_ready),
        .buf_ready    (buf_ready),
        .out_valid    (out_valid),
        .res          (res)
    );

endmodule

`default_nettype wire
